// File: include/aquila_mem_settings.svh
`ifndef AQUILA_MEM_SETTINGS_SVH
`define AQUILA_MEM_SETTINGS_SVH

// Data and address width
`define AQ_XLEN           32

// TCM depth in words
`define AQ_TCM_WORDS      1024

// Segment codes in the top address nibble
// Any other nibble falls into the cached DRAM segment
`define AQ_SEG_TCM        4'h0
`define AQ_SEG_DEV        4'hC
`define AQ_SEG_SYS        4'hF

// Address bits 19..16 inside the system segment that select the timer
`define AQ_CLINT_PAGE     4'h0

// Timer word offsets, address bits 4..2
`define AQ_CLINT_MSIP     3'd0
`define AQ_CLINT_CMP_LO   3'd2
`define AQ_CLINT_CMP_HI   3'd3
`define AQ_CLINT_TIME_LO  3'd4
`define AQ_CLINT_TIME_HI  3'd5

// Timer compare starts far in the future
`define AQ_CMP_RESET      64'hFFFF_FFFF_FFFF_FFFF

`endif

// File: hdl/aquila_mem_pkg.sv
`include "aquila_mem_settings.svh"

package aquila_mem_pkg;

    // ------------------------------
    // Plain vectors
    // ------------------------------
    typedef logic [`AQ_XLEN-1:0]               word_t;
    typedef logic [`AQ_XLEN-1:0]               addr_t;
    typedef logic [`AQ_XLEN/8-1:0]             byte_en_t;
    typedef logic [$clog2(`AQ_TCM_WORDS)-1:0]  tcm_index_t;
    typedef logic [2:0]                        clint_off_t;

    // ------------------------------
    // State and select encodings
    // ------------------------------
    typedef enum logic [1:0] {
        SEG_TCM  = 2'd0,
        SEG_DRAM = 2'd1,
        SEG_DEV  = 2'd2,
        SEG_SYS  = 2'd3
    } seg_sel_t;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_I    = 2'd1,
        ARB_D    = 2'd2
    } arb_state_t;

    // ------------------------------
    // Request and response bundles
    // ------------------------------
    // Data-side request, 70 bits
    typedef struct packed {
        logic     strobe;
        logic     rw;
        addr_t    addr;
        byte_en_t byte_en;
        word_t    wdata;
    } mem_req_t;

    // Ready level plus read word, 33 bits
    typedef struct packed {
        logic  ready;
        word_t rdata;
    } mem_rsp_t;

    // Instruction fetch, read only
    typedef struct packed {
        logic  strobe;
        addr_t addr;
    } fetch_req_t;

    // Refill request from one cache port
    typedef struct packed {
        logic  strobe;
        logic  rw;
        addr_t addr;
        logic  share_modify;
        logic  replacement;
    } refill_req_t;

    // Shared refill channel toward the coherence unit
    typedef struct packed {
        logic  strobe;
        logic  rw;
        addr_t addr;
        logic  share_modify;
        logic  replacement;
        logic  is_instr_fetch;
    } refill_out_t;

endpackage

// File: hdl/segment_router.sv
`timescale 1ns/1ps
`include "aquila_mem_settings.svh"

module segment_router (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  aquila_mem_pkg::fetch_req_t fetch_i,
    output aquila_mem_pkg::fetch_req_t fetch_tcm_o,
    input  aquila_mem_pkg::mem_req_t   data_i,
    output aquila_mem_pkg::mem_rsp_t   data_o,
    output aquila_mem_pkg::mem_req_t   tcm_req_o,
    input  aquila_mem_pkg::mem_rsp_t   tcm_rsp_i,
    output aquila_mem_pkg::mem_req_t   clint_req_o,
    input  aquila_mem_pkg::mem_rsp_t   clint_rsp_i,
    output aquila_mem_pkg::mem_req_t   dev_req_o,
    input  aquila_mem_pkg::mem_rsp_t   dev_rsp_i
);

    import aquila_mem_pkg::*;

    seg_sel_t data_sel;
    seg_sel_t data_sel_q;
    logic     clint_page;
    logic     clint_page_q;
    mem_rsp_t stub_rsp;

    // Keep a request but mask strobe and write outside its target
    function automatic mem_req_t gate_req(input mem_req_t req, input logic hit);
        mem_req_t g;
        g        = req;
        g.strobe = req.strobe & hit;
        g.rw     = req.rw & hit;
        return g;
    endfunction

    // ------------------------------
    // Address decode
    // ------------------------------
    always_comb begin
        case (data_i.addr[`AQ_XLEN-1 -: 4])
            `AQ_SEG_TCM: data_sel = SEG_TCM;
            `AQ_SEG_DEV: data_sel = SEG_DEV;
            `AQ_SEG_SYS: data_sel = SEG_SYS;
            default:     data_sel = SEG_DRAM;
        endcase
    end

    // Timer page inside the system segment
    assign clint_page = (data_i.addr[19:16] == `AQ_CLINT_PAGE);

    // Fetches only reach the TCM
    // Anything else never sees a strobe and stays unanswered
    assign fetch_tcm_o.strobe = fetch_i.strobe &&
                                (fetch_i.addr[`AQ_XLEN-1 -: 4] == `AQ_SEG_TCM);
    assign fetch_tcm_o.addr   = fetch_i.addr;

    // ------------------------------
    // Downstream requests
    // ------------------------------
    assign tcm_req_o   = gate_req(data_i, data_sel == SEG_TCM);
    assign clint_req_o = gate_req(data_i, (data_sel == SEG_SYS) && clint_page);

    // Device bus shows nothing but segment C traffic
    always_comb begin
        dev_req_o = gate_req(data_i, data_sel == SEG_DEV);
        if (data_sel != SEG_DEV) begin
            dev_req_o.addr  = '0;
            dev_req_o.wdata = '0;
        end
    end

    // ------------------------------
    // Response steering
    // ------------------------------
    // Select follows the address by one cycle so it lines up with the answer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            data_sel_q   <= SEG_TCM;
            clint_page_q <= 1'b0;
        end else begin
            data_sel_q   <= data_sel;
            clint_page_q <= clint_page;
        end
    end

    // DRAM and unmapped system pages just answer with zero
    assign stub_rsp = '{ready: 1'b1, rdata: '0};

    always_comb begin
        case (data_sel_q)
            SEG_TCM: data_o = tcm_rsp_i;
            SEG_DEV: data_o = dev_rsp_i;
            SEG_SYS: data_o = clint_page_q ? clint_rsp_i : stub_rsp;
            default: data_o = stub_rsp;
        endcase
    end

endmodule

// File: hdl/tcm_dp.sv
`timescale 1ns/1ps
`include "aquila_mem_settings.svh"

module tcm_dp (
    input  logic                       clk_i,
    input  aquila_mem_pkg::fetch_req_t port_a_i,
    output aquila_mem_pkg::mem_rsp_t   port_a_o,
    input  aquila_mem_pkg::mem_req_t   port_b_i,
    output aquila_mem_pkg::mem_rsp_t   port_b_o
);

    import aquila_mem_pkg::*;

    word_t      mem [0:`AQ_TCM_WORDS-1];
    tcm_index_t idx_a;
    tcm_index_t idx_b;
    logic       ready_a_q;
    logic       ready_b_q;
    word_t      rdata_a_q;
    word_t      rdata_b_q;

    // Word index from the byte address
    assign idx_a = port_a_i.addr[$bits(tcm_index_t)+1:2];
    assign idx_b = port_b_i.addr[$bits(tcm_index_t)+1:2];

    // ------------------------------
    // Port A, instruction fetch
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (port_a_i.strobe) begin
            rdata_a_q <= mem[idx_a];
        end
        ready_a_q <= port_a_i.strobe;
    end

    // ------------------------------
    // Port B, data read and write
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (port_b_i.strobe) begin
            if (port_b_i.rw) begin
                // Only enabled byte lanes change
                for (int i = 0; i < $bits(byte_en_t); i++) begin
                    if (port_b_i.byte_en[i]) begin
                        mem[idx_b][8*i +: 8] <= port_b_i.wdata[8*i +: 8];
                    end
                end
            end
            // Old word comes back on a write too
            rdata_b_q <= mem[idx_b];
        end
        ready_b_q <= port_b_i.strobe;
    end

    assign port_a_o = '{ready: ready_a_q, rdata: rdata_a_q};
    assign port_b_o = '{ready: ready_b_q, rdata: rdata_b_q};

endmodule

// File: hdl/clint_timer.sv
`timescale 1ns/1ps
`include "aquila_mem_settings.svh"

module clint_timer (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  aquila_mem_pkg::mem_req_t req_i,
    output aquila_mem_pkg::mem_rsp_t rsp_o,
    output logic                     tmr_irq_o,
    output logic                     sft_irq_o
);

    import aquila_mem_pkg::*;

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        msip_q;
    logic        tmr_irq_q;
    logic        ready_q;
    word_t       rdata_q;
    word_t       rd_word;
    clint_off_t  off;
    logic        wr_en;

    assign off   = req_i.addr[4:2];
    assign wr_en = req_i.strobe & req_i.rw;

    // ------------------------------
    // Time counter
    // ------------------------------
    // Free running, a word write replaces one half for that cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mtime_q <= '0;
        end else if (wr_en && off == `AQ_CLINT_TIME_LO) begin
            mtime_q <= {mtime_q[63:32], req_i.wdata};
        end else if (wr_en && off == `AQ_CLINT_TIME_HI) begin
            mtime_q <= {req_i.wdata, mtime_q[31:0]};
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // ------------------------------
    // Compare and software bit
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mtimecmp_q <= `AQ_CMP_RESET;
            msip_q     <= 1'b0;
        end else if (wr_en) begin
            case (off)
                `AQ_CLINT_MSIP:   msip_q            <= req_i.wdata[0];
                `AQ_CLINT_CMP_LO: mtimecmp_q[31:0]  <= req_i.wdata;
                `AQ_CLINT_CMP_HI: mtimecmp_q[63:32] <= req_i.wdata;
                default: ;
            endcase
        end
    end

    // Timer interrupt level, registered
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tmr_irq_q <= 1'b0;
        end else begin
            tmr_irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    // ------------------------------
    // Read path
    // ------------------------------
    always_comb begin
        case (off)
            `AQ_CLINT_MSIP:    rd_word = word_t'(msip_q);
            `AQ_CLINT_CMP_LO:  rd_word = mtimecmp_q[31:0];
            `AQ_CLINT_CMP_HI:  rd_word = mtimecmp_q[63:32];
            `AQ_CLINT_TIME_LO: rd_word = mtime_q[31:0];
            `AQ_CLINT_TIME_HI: rd_word = mtime_q[63:32];
            default:           rd_word = '0;
        endcase
    end

    // One cycle answer, same as the TCM
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= req_i.strobe;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.strobe) begin
            rdata_q <= rd_word;
        end
    end

    assign rsp_o     = '{ready: ready_q, rdata: rdata_q};
    assign tmr_irq_o = tmr_irq_q;
    assign sft_irq_o = msip_q;

endmodule

// File: hdl/refill_arbiter.sv
`timescale 1ns/1ps

module refill_arbiter (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  aquila_mem_pkg::refill_req_t icache_req_i,
    output logic                        icache_ready_o,
    input  aquila_mem_pkg::refill_req_t dcache_req_i,
    output logic                        dcache_ready_o,
    output aquila_mem_pkg::refill_out_t cu_req_o,
    input  logic                        cu_ready_i
);

    import aquila_mem_pkg::*;

    arb_state_t  state_q;
    arb_state_t  state_d;
    refill_out_t cu_req_q;

    // ------------------------------
    // Grant FSM
    // ------------------------------
    // Instruction side wins a tie in idle
    always_comb begin
        case (state_q)
            ARB_IDLE: begin
                if (icache_req_i.strobe) begin
                    state_d = ARB_I;
                end else if (dcache_req_i.strobe) begin
                    state_d = ARB_D;
                end else begin
                    state_d = ARB_IDLE;
                end
            end
            // Owner keeps the channel until the response
            ARB_I:   state_d = cu_ready_i ? ARB_IDLE : ARB_I;
            ARB_D:   state_d = cu_ready_i ? ARB_IDLE : ARB_D;
            default: state_d = ARB_IDLE;
        endcase
    end

    // ------------------------------
    // Outgoing request register
    // ------------------------------
    // Loaded from the next state so the strobe rises on the grant edge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= ARB_IDLE;
            cu_req_q <= '0;
        end else begin
            state_q <= state_d;
            case (state_d)
                ARB_I: begin
                    // Fetch refills are plain reads
                    cu_req_q <= '{strobe:         1'b1,
                                  rw:             1'b0,
                                  addr:           icache_req_i.addr,
                                  share_modify:   1'b0,
                                  replacement:    1'b0,
                                  is_instr_fetch: 1'b1};
                end
                ARB_D: begin
                    cu_req_q <= '{strobe:         1'b1,
                                  rw:             dcache_req_i.rw,
                                  addr:           dcache_req_i.addr,
                                  share_modify:   dcache_req_i.share_modify,
                                  replacement:    dcache_req_i.replacement,
                                  is_instr_fetch: 1'b0};
                end
                default: cu_req_q <= '0;
            endcase
        end
    end

    assign cu_req_o = cu_req_q;

    // Response goes back only to the current owner
    assign icache_ready_o = (state_q == ARB_I) & cu_ready_i;
    assign dcache_ready_o = (state_q == ARB_D) & cu_ready_i;

endmodule

// File: hdl/aquila_mem_top.sv
`timescale 1ns/1ps

module aquila_mem_top (
    input  logic                        clk_i,
    input  logic                        rst_i,

    // Core instruction port
    input  aquila_mem_pkg::fetch_req_t  fetch_i,
    output aquila_mem_pkg::mem_rsp_t    fetch_o,

    // Core data port
    input  aquila_mem_pkg::mem_req_t    data_i,
    output aquila_mem_pkg::mem_rsp_t    data_o,

    // Uncached device bus
    output aquila_mem_pkg::mem_req_t    dev_o,
    input  aquila_mem_pkg::mem_rsp_t    dev_i,

    // Cache refill ports
    input  aquila_mem_pkg::refill_req_t icache_refill_i,
    output logic                        icache_ready_o,
    input  aquila_mem_pkg::refill_req_t dcache_refill_i,
    output logic                        dcache_ready_o,

    // Coherence unit channel
    output aquila_mem_pkg::refill_out_t cu_req_o,
    input  logic                        cu_ready_i,

    // Interrupt levels toward the core
    output logic                        tmr_irq_o,
    output logic                        sft_irq_o
);

    import aquila_mem_pkg::*;

    fetch_req_t fetch_tcm;
    mem_req_t   tcm_req;
    mem_rsp_t   tcm_rsp;
    mem_req_t   clint_req;
    mem_rsp_t   clint_rsp;

    // ------------------------------
    // Memory map
    // ------------------------------
    segment_router u_router (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .fetch_i     (fetch_i),
        .fetch_tcm_o (fetch_tcm),
        .data_i      (data_i),
        .data_o      (data_o),
        .tcm_req_o   (tcm_req),
        .tcm_rsp_i   (tcm_rsp),
        .clint_req_o (clint_req),
        .clint_rsp_i (clint_rsp),
        .dev_req_o   (dev_o),
        .dev_rsp_i   (dev_i)
    );

    // Port A serves fetches, port B serves data
    tcm_dp u_tcm (
        .clk_i    (clk_i),
        .port_a_i (fetch_tcm),
        .port_a_o (fetch_o),
        .port_b_i (tcm_req),
        .port_b_o (tcm_rsp)
    );

    // ------------------------------
    // System devices
    // ------------------------------
    clint_timer u_clint (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (clint_req),
        .rsp_o     (clint_rsp),
        .tmr_irq_o (tmr_irq_o),
        .sft_irq_o (sft_irq_o)
    );

    // ------------------------------
    // Refill channel sharing
    // ------------------------------
    refill_arbiter u_arb (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .icache_req_i   (icache_refill_i),
        .icache_ready_o (icache_ready_o),
        .dcache_req_i   (dcache_refill_i),
        .dcache_ready_o (dcache_ready_o),
        .cu_req_o       (cu_req_o),
        .cu_ready_i     (cu_ready_i)
    );

endmodule

// File: tb/tb_aquila_mem.sv
`timescale 1ns/1ps
`include "aquila_mem_settings.svh"

module tb_aquila_mem;

    import aquila_mem_pkg::*;

    // Row kinds of the stimulus table
    localparam logic [2:0] K_DATA   = 3'd0;
    localparam logic [2:0] K_FETCH  = 3'd1;
    localparam logic [2:0] K_IRQ    = 3'd2;
    localparam logic [2:0] K_TIME   = 3'd3;
    localparam logic [2:0] K_CMP    = 3'd4;
    localparam logic [2:0] K_REFILL = 3'd5;

    // One table row
    // K_IRQ rows keep {tmr, sft} in exp[1:0] and the wait limit in wdata
    typedef struct packed {
        logic [2:0] kind;
        logic       rw;
        addr_t      addr;
        byte_en_t   be;
        word_t      wdata;
        word_t      exp;
    } row_t;

    logic        clk_i = 1'b0;
    logic        rst_i;
    fetch_req_t  fetch_i;
    mem_rsp_t    fetch_o;
    mem_req_t    data_i;
    mem_rsp_t    data_o;
    mem_req_t    dev_o;
    mem_rsp_t    dev_i = '0;
    refill_req_t icache_refill_i;
    logic        icache_ready_o;
    refill_req_t dcache_refill_i;
    logic        dcache_ready_o;
    refill_out_t cu_req_o;
    logic        cu_ready_i = 1'b0;
    logic        tmr_irq_o;
    logic        sft_irq_o;

    row_t        rows[$];
    refill_out_t cu_seen[$];
    word_t       tcm_model [0:`AQ_TCM_WORDS-1];
    word_t       last_time;
    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    int unsigned lcg_state = 70851;
    logic [1:0]  dev_cnt;
    addr_t       dev_addr;
    logic        cu_busy;
    logic [2:0]  cu_cnt;
    logic        cu_ready_force;

    aquila_mem_top dut0 (.*);

    always #4 clk_i = ~clk_i;

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expv);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("FAILURE at %0t: %s", $time, msg);
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 1103515245 + 12345;
        return (lcg_state >> 16) & 32'h7FFF;
    endfunction

    // Reference TCM write where only enabled lanes change
    function automatic void model_write(input addr_t addr, input byte_en_t be,
                                        input word_t wdata);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                tcm_model[addr[11:2]][8*i +: 8] = wdata[8*i +: 8];
            end
        end
    endfunction

    task automatic add_row(input logic [2:0] kind, input logic rw, input addr_t addr,
                           input byte_en_t be, input word_t wdata, input word_t exp);
        rows.push_back('{kind: kind, rw: rw, addr: addr, be: be, wdata: wdata, exp: exp});
    endtask

    // ------------------------------
    // Device and coherence-unit models
    // ------------------------------
    // Device answers two cycles after the strobe and then holds off one cycle
    always @(posedge clk_i) begin
        if (rst_i) begin
            dev_cnt <= 2'd0;
        end else if (dev_cnt != 2'd0) begin
            dev_cnt <= dev_cnt + 2'd1;
        end else if (dev_o.strobe) begin
            dev_cnt  <= 2'd1;
            dev_addr <= dev_o.addr;
        end
    end

    always @(negedge clk_i) begin
        dev_i <= '{ready: dev_cnt == 2'd2,
                   rdata: (dev_cnt == 2'd2) ? {dev_addr[15:0], 16'hD0D0} : 32'h0};
    end

    // Coherence unit takes a random number of cycles per refill
    always @(posedge clk_i) begin
        if (rst_i) begin
            cu_busy <= 1'b0;
            cu_cnt  <= 3'd0;
        end else if (cu_busy && cu_ready_i) begin
            cu_busy <= 1'b0;
        end else if (!cu_busy && cu_req_o.strobe) begin
            cu_busy <= 1'b1;
            cu_cnt  <= 3'(lcg_next() % 5);
            cu_seen.push_back(cu_req_o);
        end else if (cu_busy && cu_cnt != 3'd0) begin
            cu_cnt <= cu_cnt - 3'd1;
        end
    end

    // Response level can also be held high around reset with no refill pending
    always @(negedge clk_i) begin
        cu_ready_i <= (cu_busy && (cu_cnt == 3'd0)) || cu_ready_force;
    end

    // Run limit follows the table length
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= rows.size() * 40 + 600) begin
            $display("Timeout: run still going after %0d cycles", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Bus tasks
    // ------------------------------
    // Data port access with the device bus checked on the first strobed edge
    task automatic data_access(input row_t r, output word_t rdata);
        int   cyc;
        logic dev_hit;
        dev_hit = (r.addr[31:28] == `AQ_SEG_DEV);
        @(negedge clk_i);
        data_i = '{strobe: 1'b1, rw: r.rw, addr: r.addr, byte_en: r.be, wdata: r.wdata};
        cyc = 0;
        do begin
            @(posedge clk_i);
            cyc++;
            if (cyc == 1) begin
                check_value("dev_o.strobe", dev_o.strobe, dev_hit);
                check_value("dev_o.rw", dev_o.rw, dev_hit & r.rw);
                check_value("dev_o.addr", dev_o.addr, dev_hit ? r.addr : 32'h0);
                check_value("dev_o.wdata", dev_o.wdata, dev_hit ? r.wdata : 32'h0);
                if (dev_hit) begin
                    check_value("dev_o.byte_en", dev_o.byte_en, r.be);
                end
            end
        end while (!data_o.ready && cyc < 20);
        if (!data_o.ready) begin
            note_failure($sformatf("data access to %h was never answered", r.addr));
        end
        // Device adds its own latency while everything else answers next cycle
        check_value("data_o ready cycle", cyc, dev_hit ? 3 : 2);
        rdata = data_o.rdata;
        @(negedge clk_i);
        data_i = '0;
    endtask

    task automatic run_refill(input addr_t i_addr, input addr_t d_addr);
        int          cyc;
        int          i_cnt;
        int          d_cnt;
        refill_out_t seen;
        cu_seen.delete();
        i_cnt = 0;
        d_cnt = 0;
        cyc   = 0;
        @(negedge clk_i);
        // Instruction side asks for write fields that the arbiter must drop
        icache_refill_i = '{strobe: 1'b1, rw: 1'b1, addr: i_addr,
                            share_modify: 1'b1, replacement: 1'b1};
        dcache_refill_i = '{strobe: 1'b1, rw: 1'b1, addr: d_addr,
                            share_modify: 1'b1, replacement: 1'b0};
        while ((i_cnt == 0 || d_cnt == 0) && cyc < 100) begin
            @(posedge clk_i);
            cyc++;
            if (icache_ready_o) begin
                check_value("icache grant", {cu_req_o.strobe, cu_req_o.is_instr_fetch}, 2'b11);
                i_cnt++;
            end
            if (dcache_ready_o) begin
                check_value("dcache grant", {cu_req_o.strobe, cu_req_o.is_instr_fetch}, 2'b10);
                check_value("icache served before dcache", i_cnt, 1);
                d_cnt++;
            end
            @(negedge clk_i);
            if (i_cnt != 0) begin
                icache_refill_i = '0;
            end
            if (d_cnt != 0) begin
                dcache_refill_i = '0;
            end
        end
        if (i_cnt == 0 || d_cnt == 0) begin
            note_failure("refill requests were not both answered");
        end
        // Channel must stay quiet once both are served
        repeat (6) begin
            @(posedge clk_i);
            check_value("cu_req_o.strobe idle", cu_req_o.strobe, 1'b0);
        end
        check_value("refill strobe sequences", cu_seen.size(), 2);
        if (cu_seen.size() == 2) begin
            seen = cu_seen[0];
            check_value("first refill addr", seen.addr, i_addr);
            check_value("first refill flags", {seen.rw, seen.share_modify,
                        seen.replacement, seen.is_instr_fetch}, 4'b0001);
            seen = cu_seen[1];
            check_value("second refill addr", seen.addr, d_addr);
            check_value("second refill flags", {seen.rw, seen.share_modify,
                        seen.replacement, seen.is_instr_fetch}, 4'b1100);
        end
    endtask

    // ------------------------------
    // Table walk
    // ------------------------------
    task automatic apply_row(input row_t r);
        word_t rdata;
        row_t  cr;
        int    cyc;
        case (r.kind)
            K_DATA: begin
                data_access(r, rdata);
                if (r.rw && r.addr[31:28] == `AQ_SEG_TCM) begin
                    model_write(r.addr, r.be, r.wdata);
                end else if (!r.rw) begin
                    check_value("data_o.rdata", rdata,
                        (r.addr[31:28] == `AQ_SEG_TCM) ? tcm_model[r.addr[11:2]] : r.exp);
                end
            end
            K_FETCH: begin
                @(negedge clk_i);
                fetch_i = '{strobe: 1'b1, addr: r.addr};
                cyc = 0;
                do begin
                    @(posedge clk_i);
                    cyc++;
                end while (!fetch_o.ready && cyc < 20);
                check_value("fetch_o ready cycle", cyc, 2);
                check_value("fetch_o.rdata", fetch_o.rdata, tcm_model[r.addr[11:2]]);
                @(negedge clk_i);
                fetch_i = '0;
            end
            K_IRQ: begin
                cyc = 0;
                while ({tmr_irq_o, sft_irq_o} != r.exp[1:0] && cyc < r.wdata) begin
                    @(posedge clk_i);
                    cyc++;
                end
                check_value("tmr_irq_o", tmr_irq_o, r.exp[1]);
                check_value("sft_irq_o", sft_irq_o, r.exp[0]);
            end
            K_TIME: begin
                data_access(r, rdata);
                if (r.exp != 0) begin
                    check_value("time increasing", rdata > last_time, 1'b1);
                end
                last_time = rdata;
            end
            K_CMP: begin
                // Compare lands a little ahead of the last time read
                cr       = r;
                cr.rw    = 1'b1;
                cr.wdata = last_time + r.wdata;
                data_access(cr, rdata);
            end
            K_REFILL: run_refill(r.addr, r.wdata);
            default: note_failure("unknown row kind in stimulus table");
        endcase
    endtask

    task automatic build_table();
        // TCM writes with mixed lanes followed by reads on both ports
        add_row(K_DATA,  1, 32'h0000_0000, 4'hF, 32'h1122_3344, 0);
        add_row(K_DATA,  1, 32'h0000_0004, 4'hF, 32'h5566_7788, 0);
        add_row(K_DATA,  1, 32'h0000_0FFC, 4'hF, 32'hCAFE_F00D, 0);
        add_row(K_DATA,  1, 32'h0000_0000, 4'h5, 32'hAABB_CCDD, 0);
        add_row(K_DATA,  1, 32'h0000_0004, 4'hA, 32'h99AA_BBCC, 0);
        add_row(K_DATA,  1, 32'h0000_0FFC, 4'h1, 32'h0000_00EE, 0);
        add_row(K_DATA,  0, 32'h0000_0000, 4'hF, 0, 0);
        add_row(K_DATA,  0, 32'h0000_0004, 4'hF, 0, 0);
        add_row(K_DATA,  0, 32'h0000_0FFC, 4'hF, 0, 0);
        add_row(K_FETCH, 0, 32'h0000_0000, 4'h0, 0, 0);
        add_row(K_FETCH, 0, 32'h0000_0004, 4'h0, 0, 0);
        add_row(K_FETCH, 0, 32'h0000_0FFC, 4'h0, 0, 0);
        // Device segment reads return {addr[15:0], D0D0}
        add_row(K_DATA,  1, 32'hC000_0010, 4'h3, 32'h1234_5678, 0);
        add_row(K_DATA,  0, 32'hC000_0124, 4'hF, 0, 32'h0124_D0D0);
        add_row(K_DATA,  0, 32'hC000_BEE8, 4'hF, 0, 32'hBEE8_D0D0);
        // DRAM and unmapped system pages
        add_row(K_DATA,  1, 32'h8000_0004, 4'hF, 32'hDEAD_BEEF, 0);
        add_row(K_DATA,  0, 32'h8000_0040, 4'hF, 0, 0);
        add_row(K_DATA,  1, 32'hF001_0000, 4'hF, 32'h0000_0001, 0);
        add_row(K_DATA,  0, 32'hF002_0010, 4'hF, 0, 0);
        add_row(K_DATA,  0, 32'h0000_0000, 4'hF, 0, 0);
        add_row(K_DATA,  0, 32'h0000_0004, 4'hF, 0, 0);
        add_row(K_FETCH, 0, 32'h0000_0004, 4'h0, 0, 0);
        // Timer and software interrupt
        add_row(K_IRQ,   0, 0, 4'h0, 4, 2'b00);
        add_row(K_DATA,  1, 32'hF000_0000, 4'hF, 32'h1, 0);
        add_row(K_IRQ,   0, 0, 4'h0, 4, 2'b01);
        add_row(K_DATA,  0, 32'hF000_0000, 4'hF, 0, 32'h1);
        add_row(K_DATA,  1, 32'hF000_0000, 4'hF, 32'h0, 0);
        add_row(K_IRQ,   0, 0, 4'h0, 4, 2'b00);
        add_row(K_TIME,  0, 32'hF000_0010, 4'hF, 0, 0);
        add_row(K_TIME,  0, 32'hF000_0010, 4'hF, 0, 1);
        add_row(K_DATA,  1, 32'hF000_000C, 4'hF, 32'h0, 0);
        add_row(K_DATA,  0, 32'hF000_000C, 4'hF, 0, 32'h0);
        add_row(K_CMP,   1, 32'hF000_0008, 4'hF, 64, 0);
        add_row(K_IRQ,   0, 0, 4'h0, 200, 2'b10);
        add_row(K_DATA,  1, 32'hF000_000C, 4'hF, 32'hFFFF_FFFF, 0);
        add_row(K_IRQ,   0, 0, 4'h0, 4, 2'b00);
        // Refill arbitration with the instruction address first and the data address second
        add_row(K_REFILL, 0, 32'h8000_1000, 4'h0, 32'h9000_2040, 0);
        add_row(K_REFILL, 0, 32'h8000_3000, 4'h0, 32'h8000_4080, 0);
    endtask

    initial begin
        rst_i           = 1'b1;
        cu_ready_force  = 1'b1;
        fetch_i         = '0;
        data_i          = '0;
        icache_refill_i = '0;
        dcache_refill_i = '0;
        last_time       = '0;
        build_table();
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        // Quiet outputs straight after reset, readies stay low with the response level high
        check_value("cu_req_o.strobe", cu_req_o.strobe, 1'b0);
        check_value("tmr_irq_o", tmr_irq_o, 1'b0);
        check_value("sft_irq_o", sft_irq_o, 1'b0);
        check_value("icache_ready_o", icache_ready_o, 1'b0);
        check_value("dcache_ready_o", dcache_ready_o, 1'b0);
        @(posedge clk_i);
        cu_ready_force = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        repeat (4) @(negedge clk_i);
        $display("Summary: %0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: aquila_mem.f
+incdir+include
hdl/aquila_mem_pkg.sv
hdl/segment_router.sv
hdl/tcm_dp.sv
hdl/clint_timer.sv
hdl/refill_arbiter.sv
hdl/aquila_mem_top.sv
tb/tb_aquila_mem.sv
